//--- rtl/rename_settings.svh
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// architectural register count of rv32i
`define RENAME_ARCH_REGS 32

// physical register file size
// the upper half starts out on the free list
`define RENAME_PHYS_REGS 64

// reorder buffer entries, power of two
`define RENAME_ROB_DEPTH 16

`endif

//--- rtl/rename_pkg.sv
`include "rename_settings.svh"

package rename_pkg;

    // register numbers
    typedef logic [$clog2(`RENAME_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`RENAME_PHYS_REGS)-1:0] phys_reg_t;

    // slot in the reorder buffer
    typedef logic [$clog2(`RENAME_ROB_DEPTH)-1:0] rob_idx_t;

    // entry leaving the rob at commit
    typedef struct packed {
        arch_reg_t arch;
        phys_reg_t phys;
    } rob_out_t;

    // one completion broadcast
    typedef struct packed {
        logic     valid;
        rob_idx_t rob_idx;
    } cdb_t;

    // one rob slot
    typedef struct packed {
        logic      valid;   // slot holds an instruction
        logic      done;    // result written back
        arch_reg_t arch;
        phys_reg_t phys;
    } rob_entry_t;

endpackage

//--- rtl/rob.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rob #(
    parameter int QUEUE_DEPTH = `RENAME_ROB_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,

    // from rename
    input  logic                  enqueue,
    input  rename_pkg::arch_reg_t enq_arch,
    input  rename_pkg::phys_reg_t enq_phys,

    // completion broadcasts
    input  rename_pkg::cdb_t      add_cdb,
    input  rename_pkg::cdb_t      mul_cdb,
    input  rename_pkg::cdb_t      div_cdb,

    // slot the next dispatch will take
    output rename_pkg::rob_idx_t  rob_num,
    output logic                  full,

    // to the retirement map
    output logic                  commit_valid,
    output rename_pkg::rob_out_t  commit
);

    import rename_pkg::*;

    localparam int ADDR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int NUM_CDB    = 3;

    // pointers carry one wrap bit above the slot bits
    // tail marks the youngest entry, head the last one retired
    logic [ADDR_WIDTH:0]   tail_ptr;
    logic [ADDR_WIDTH:0]   head_ptr;

    logic [ADDR_WIDTH-1:0] tail_slot;   // where the next enqueue lands
    logic [ADDR_WIDTH-1:0] head_slot;   // oldest live entry

    rob_entry_t            mem [QUEUE_DEPTH];
    rob_entry_t            head_entry;
    rob_entry_t            new_entry;

    cdb_t                  cdb [NUM_CDB];

    assign tail_slot = tail_ptr[ADDR_WIDTH-1:0] + 1'b1;
    assign head_slot = head_ptr[ADDR_WIDTH-1:0] + 1'b1;

    assign rob_num = tail_slot;

    // same slot bits, opposite wrap bits
    assign full = (tail_ptr[ADDR_WIDTH-1:0] == head_ptr[ADDR_WIDTH-1:0]) &&
                  (tail_ptr[ADDR_WIDTH] != head_ptr[ADDR_WIDTH]);

    assign head_entry   = mem[head_slot];
    assign commit_valid = head_entry.valid && head_entry.done;

    always_comb begin
        commit.arch = head_entry.arch;
        commit.phys = head_entry.phys;
    end

    // fresh entry, waiting on its execution unit
    always_comb begin
        new_entry.valid = 1'b1;
        new_entry.done  = 1'b0;
        new_entry.arch  = enq_arch;
        new_entry.phys  = enq_phys;
    end

    // all three ports are handled the same way
    assign cdb[0] = add_cdb;
    assign cdb[1] = mul_cdb;
    assign cdb[2] = div_cdb;

    always_ff @(posedge clk) begin
        if (rst) begin
            tail_ptr <= '1;  // slot 0 comes first
            head_ptr <= '1;
        end else begin
            if (enqueue) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (commit_valid) begin
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                mem[i].valid <= 1'b0;
                mem[i].done  <= 1'b0;
            end
        end else begin
            // retire the head, it was shown on commit this cycle
            if (commit_valid) begin
                mem[head_slot].valid <= 1'b0;
                mem[head_slot].done  <= 1'b0;
            end

            // enqueue never targets the head slot while it is live
            if (enqueue) begin
                mem[tail_slot] <= new_entry;
            end

            // several ports may finish in one cycle, each on its own slot
            for (int p = 0; p < NUM_CDB; p++) begin
                if (cdb[p].valid) begin
                    mem[cdb[p].rob_idx].done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/free_list.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module free_list (
    input  logic                  clk,
    input  logic                  rst,

    // allocate on rename
    input  logic                  pop,

    // superseded register returned at commit
    input  logic                  push,
    input  rename_pkg::phys_reg_t push_phys,

    output rename_pkg::phys_reg_t head_phys,
    output logic                  empty
);

    import rename_pkg::*;

    // every physical register above the identity map
    localparam int DEPTH     = `RENAME_PHYS_REGS - `RENAME_ARCH_REGS;
    localparam int PTR_WIDTH = $clog2(DEPTH);

    phys_reg_t            mem [DEPTH];
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH:0]   count;    // one extra bit to hold DEPTH

    assign head_phys = mem[rd_ptr];
    assign empty     = (count == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // starts full, wr_ptr has wrapped back onto rd_ptr
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= (PTR_WIDTH+1)'(DEPTH);
        end else begin
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // contents are part of the reset state here
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= phys_reg_t'(`RENAME_ARCH_REGS + i);  // 32 up to 63
            end
        end else if (push) begin
            // lands behind everything still queued
            mem[wr_ptr] <= push_phys;
        end
    end

endmodule

//--- rtl/rat.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rat (
    input  logic                  clk,
    input  logic                  rst,

    // source lookups
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    output rename_pkg::phys_reg_t rs1_phys,
    output rename_pkg::phys_reg_t rs2_phys,

    // destination rename
    input  rename_pkg::arch_reg_t rd,
    input  logic                  write,
    input  rename_pkg::phys_reg_t rd_phys
);

    import rename_pkg::*;

    localparam int NUM_REGS = `RENAME_ARCH_REGS;

    // speculative map, runs ahead of the committed one in rrf
    phys_reg_t map [NUM_REGS];

    // read before this cycle's write
    // so rs == rd still sees the older producer
    assign rs1_phys = map[rs1];
    assign rs2_phys = map[rs2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                map[i] <= phys_reg_t'(i);  // identity
            end
        end else if (write) begin
            map[rd] <= rd_phys;
        end
    end

endmodule

//--- rtl/rrf.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rrf (
    input  logic                  clk,
    input  logic                  rst,

    // retiring entry from the rob
    input  logic                  commit_valid,
    input  rename_pkg::rob_out_t  commit,

    // previous owner of commit.arch, goes back to the free list
    output rename_pkg::phys_reg_t freed_phys
);

    import rename_pkg::*;

    localparam int NUM_REGS = `RENAME_ARCH_REGS;

    // committed architectural state
    phys_reg_t map [NUM_REGS];

    // only meaningful while commit_valid is high
    assign freed_phys = map[commit.arch];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                map[i] <= phys_reg_t'(i);
            end
        end else if (commit_valid) begin
            map[commit.arch] <= commit.phys;  // new owner
        end
    end

endmodule

//--- rtl/rename_commit.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_commit (
    input  logic                  clk,
    input  logic                  rst,

    // dispatch from decode
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_reg_t dispatch_rd,
    input  rename_pkg::arch_reg_t dispatch_rs1,
    input  rename_pkg::arch_reg_t dispatch_rs2,

    // completions from the execution units
    input  rename_pkg::cdb_t      add_cdb,
    input  rename_pkg::cdb_t      mul_cdb,
    input  rename_pkg::cdb_t      div_cdb,

    output logic                  stall,
    output rename_pkg::phys_reg_t dispatch_phys_rd,
    output rename_pkg::phys_reg_t dispatch_phys_rs1,
    output rename_pkg::phys_reg_t dispatch_phys_rs2,
    output rename_pkg::rob_idx_t  dispatch_rob_idx,

    output logic                  commit_valid,
    output rename_pkg::rob_out_t  commit,
    output rename_pkg::phys_reg_t freed_phys
);

    import rename_pkg::*;

    logic      rob_full;
    logic      fl_empty;
    logic      rename_fire;
    phys_reg_t fl_head;

    // no room in the rob or nothing left to allocate
    assign stall       = rob_full | fl_empty;
    assign rename_fire = dispatch_valid & ~stall;  // dropped when stalled

    assign dispatch_phys_rd = fl_head;

    rob #(
        .QUEUE_DEPTH (`RENAME_ROB_DEPTH)
    ) u_rob (
        .clk          (clk),
        .rst          (rst),
        .enqueue      (rename_fire),
        .enq_arch     (dispatch_rd),
        .enq_phys     (fl_head),
        .add_cdb      (add_cdb),
        .mul_cdb      (mul_cdb),
        .div_cdb      (div_cdb),
        .rob_num      (dispatch_rob_idx),
        .full         (rob_full),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    free_list u_free_list (
        .clk       (clk),
        .rst       (rst),
        .pop       (rename_fire),
        .push      (commit_valid),   // one register back per commit
        .push_phys (freed_phys),
        .head_phys (fl_head),
        .empty     (fl_empty)
    );

    rat u_rat (
        .clk      (clk),
        .rst      (rst),
        .rs1      (dispatch_rs1),
        .rs2      (dispatch_rs2),
        .rs1_phys (dispatch_phys_rs1),
        .rs2_phys (dispatch_phys_rs2),
        .rd       (dispatch_rd),
        .write    (rename_fire),
        .rd_phys  (fl_head)
    );

    rrf u_rrf (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit       (commit),
        .freed_phys   (freed_phys)
    );

endmodule

//--- dv/rename_commit_sva.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_commit_sva #(
    parameter int QUEUE_DEPTH = `RENAME_ROB_DEPTH
) (
    input logic                         clk,
    input logic                         rst,
    input logic                         enqueue,
    input logic                         full,
    input logic                         commit_valid,
    input logic [$clog2(QUEUE_DEPTH):0] head_ptr,
    input logic [$clog2(QUEUE_DEPTH):0] tail_ptr,
    input rename_pkg::rob_entry_t       head_entry
);

    int fail_count = 0;  // failed assertions so far

    // rename has to hold off while the rob is full
    no_enqueue_when_full: assert property (
        @(posedge clk) disable iff (rst) !(enqueue && full)
    ) else begin
        $error("enqueue while rob full");
        fail_count++;
    end

    // first cycle out of reset, nothing to retire
    quiet_after_reset: assert property (
        @(posedge clk) (!rst && $past(rst)) |-> !commit_valid
    ) else begin
        $error("commit_valid high right after reset");
        fail_count++;
    end

    // a live head slot only while the pointers say the rob holds something
    commit_from_valid_entry: assert property (
        @(posedge clk) disable iff (rst) head_entry.valid |-> (head_ptr != tail_ptr)
    ) else begin
        $error("commit from an empty rob slot");
        fail_count++;
    end

    // head only advances on a commit
    head_moves_on_commit: assert property (
        @(posedge clk) disable iff (rst) !commit_valid |=> $stable(head_ptr)
    ) else begin
        $error("rob head moved without commit_valid");
        fail_count++;
    end

endmodule

bind rob rename_commit_sva #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_rob_sva (
    .clk          (clk),
    .rst          (rst),
    .enqueue      (enqueue),
    .full         (full),
    .commit_valid (commit_valid),
    .head_ptr     (head_ptr),
    .tail_ptr     (tail_ptr),
    .head_entry   (head_entry)
);

//--- dv/rename_commit_tb.sv
`timescale 1ns/1ps

`include "rename_settings.svh"

module rename_commit_tb;

    import rename_pkg::*;

    localparam int ARCH        = `RENAME_ARCH_REGS;
    localparam int DEPTH       = `RENAME_ROB_DEPTH;
    localparam int MAX_SEQ     = 4096;
    localparam int DRAIN_LIMIT = 200;   // cycles to empty the rob
    localparam int RANDOM_ROWS = 600;

    // sequence numbers start at 1, a zero means no completion
    typedef struct packed {
        logic        disp;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        logic [15:0] add_seq;
        logic [15:0] mul_seq;
        logic [15:0] div_seq;
        logic [1:0]  exp_stall;  // 2 means not checked
    } row_t;

    logic      clk;
    logic      rst;
    logic      dispatch_valid;
    arch_reg_t dispatch_rd;
    arch_reg_t dispatch_rs1;
    arch_reg_t dispatch_rs2;
    cdb_t      add_cdb;
    cdb_t      mul_cdb;
    cdb_t      div_cdb;
    logic      stall;
    phys_reg_t dispatch_phys_rd;
    phys_reg_t dispatch_phys_rs1;
    phys_reg_t dispatch_phys_rs2;
    rob_idx_t  dispatch_rob_idx;
    logic      commit_valid;
    rob_out_t  commit;
    phys_reg_t freed_phys;

    // reference model
    phys_reg_t m_rat [ARCH];
    phys_reg_t m_rrf [ARCH];
    phys_reg_t fl_q [$];          // free registers, head first
    int        rob_q [$];         // in-flight sequence numbers, oldest first
    arch_reg_t seq_arch [MAX_SEQ];
    phys_reg_t seq_phys [MAX_SEQ];
    rob_idx_t  seq_idx [MAX_SEQ];
    logic      seq_done [MAX_SEQ];
    int        next_seq;
    rob_idx_t  tail_idx;          // wraps with the index width

    row_t        table_rows [$];
    int          test_last [$];
    string       test_names [$];
    int          errors;
    int          commits;
    logic [31:0] rng;

    rename_commit dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic row_t make_row(input logic disp, input int rd, input int rs1,
                                      input int rs2, input int a, input int m,
                                      input int d, input int st);
        row_t r;
        r.disp      = disp;
        r.rd        = arch_reg_t'(rd);
        r.rs1       = arch_reg_t'(rs1);
        r.rs2       = arch_reg_t'(rs2);
        r.add_seq   = 16'(a);
        r.mul_seq   = 16'(m);
        r.div_seq   = 16'(d);
        r.exp_stall = 2'(st);
        return r;
    endfunction

    function automatic cdb_t to_cdb(input logic [15:0] seq);
        cdb_t c;
        c.valid   = (seq != 16'd0);
        c.rob_idx = (seq != 16'd0) ? seq_idx[seq] : '0;
        return c;
    endfunction

    // a random in-flight entry, or none if it already finished
    function automatic logic [15:0] pick_pending(input logic [31:0] rnd);
        int pos;
        if (rob_q.size() == 0) return 16'd0;
        pos = int'(rnd % rob_q.size());
        if (seq_done[rob_q[pos]]) return 16'd0;
        return 16'(rob_q[pos]);
    endfunction

    task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("Fail %s expected %h got %h at %0t", name, exp, act, $time);
        errors++;
    endtask

    task automatic end_test(input string name);
        test_names.push_back(name);
        test_last.push_back(table_rows.size());
    endtask

    // called mid cycle, then advances the model to the next edge
    task automatic check_row(input row_t r);
        logic      exp_stall;
        logic      exp_cv;
        logic      accept;
        int        s;
        phys_reg_t freed;
        exp_stall = (rob_q.size() == DEPTH) || (fl_q.size() == 0);
        exp_cv    = (rob_q.size() != 0) && seq_done[rob_q[0]];
        accept    = r.disp && !exp_stall;
        if (stall !== exp_stall) mismatch("stall", exp_stall, stall);
        if (r.exp_stall != 2'd2 && stall !== r.exp_stall[0]) mismatch("stall", r.exp_stall, stall);
        if (accept) begin
            if (dispatch_phys_rd !== fl_q[0]) mismatch("dispatch_phys_rd", fl_q[0], dispatch_phys_rd);
            if (dispatch_phys_rs1 !== m_rat[r.rs1]) begin
                mismatch("dispatch_phys_rs1", m_rat[r.rs1], dispatch_phys_rs1);
            end
            if (dispatch_phys_rs2 !== m_rat[r.rs2]) begin
                mismatch("dispatch_phys_rs2", m_rat[r.rs2], dispatch_phys_rs2);
            end
            if (dispatch_rob_idx !== tail_idx) mismatch("dispatch_rob_idx", tail_idx, dispatch_rob_idx);
        end
        if (commit_valid !== exp_cv) mismatch("commit_valid", exp_cv, commit_valid);
        if (exp_cv) begin
            s     = rob_q.pop_front();
            freed = m_rrf[seq_arch[s]];  // previous committed owner
            if (commit.arch !== seq_arch[s]) mismatch("commit.arch", seq_arch[s], commit.arch);
            if (commit.phys !== seq_phys[s]) mismatch("commit.phys", seq_phys[s], commit.phys);
            if (freed_phys !== freed) mismatch("freed_phys", freed, freed_phys);
            m_rrf[seq_arch[s]] = seq_phys[s];
            fl_q.push_back(freed);
            commits++;
        end
        if (r.add_seq != 16'd0) seq_done[r.add_seq] = 1'b1;
        if (r.mul_seq != 16'd0) seq_done[r.mul_seq] = 1'b1;
        if (r.div_seq != 16'd0) seq_done[r.div_seq] = 1'b1;
        if (accept) begin
            seq_arch[next_seq] = r.rd;
            seq_phys[next_seq] = fl_q.pop_front();
            seq_idx[next_seq]  = tail_idx;
            seq_done[next_seq] = 1'b0;
            m_rat[r.rd]        = seq_phys[next_seq];
            rob_q.push_back(next_seq);
            next_seq++;
            tail_idx++;
        end
    endtask

    task automatic run_row(input row_t r);
        @(posedge clk);
        dispatch_valid <= r.disp;
        dispatch_rd    <= r.rd;
        dispatch_rs1   <= r.rs1;
        dispatch_rs2   <= r.rs2;
        add_cdb        <= to_cdb(r.add_seq);
        mul_cdb        <= to_cdb(r.mul_seq);
        div_cdb        <= to_cdb(r.div_seq);
        @(negedge clk);  // combinational outputs settled
        check_row(r);
    endtask

    task automatic random_row(input logic allow_disp);
        row_t r;
        rng = xorshift(rng);
        r = make_row(allow_disp && (rng[1:0] != 2'd0) && (rob_q.size() < DEPTH),
                     int'(rng[6:2]) % 31 + 1, int'(rng[11:7]), int'(rng[16:12]), 0, 0, 0, 2);
        rng = xorshift(rng);
        r.add_seq = pick_pending({22'd0, rng[9:0]});
        r.mul_seq = rng[30] ? pick_pending({22'd0, rng[19:10]}) : 16'd0;
        r.div_seq = rng[31] ? pick_pending({22'd0, rng[29:20]}) : 16'd0;
        run_row(r);
    endtask

    // finish whatever is in flight and wait for the rob to empty
    task automatic drain_rob();
        int waited;
        waited = 0;
        while ((rob_q.size() != 0 || commit_valid !== 1'b0) && waited < DRAIN_LIMIT) begin
            random_row(1'b0);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            $display("timeout: rob still busy after %0d cycles of draining", DRAIN_LIMIT);
            errors++;
        end
    endtask

    task automatic build_table();
        table_rows.push_back(make_row(1, 1, 1, 2, 0, 0, 0, 0));  // seq 1
        table_rows.push_back(make_row(1, 2, 1, 2, 0, 0, 0, 0));
        table_rows.push_back(make_row(1, 1, 1, 1, 0, 0, 0, 0));  // rs == rd
        table_rows.push_back(make_row(1, 3, 2, 1, 0, 0, 0, 0));  // seq 4
        end_test("renaming");
        for (int k = 0; k < 3; k++) begin
            table_rows.push_back(make_row(1, 5 + k, k, 4, 0, 0, 0, 0));  // seq 5 to 7
        end
        table_rows.push_back(make_row(0, 0, 0, 0, 7, 0, 0, 0));  // youngest first
        table_rows.push_back(make_row(0, 0, 0, 0, 0, 6, 0, 0));
        table_rows.push_back(make_row(0, 0, 0, 0, 0, 0, 5, 0));  // head last
        end_test("in-order commit");
        // each row completes the previous one, seq 8 to 47
        for (int k = 0; k < 40; k++) begin
            table_rows.push_back(make_row(1, k % 31 + 1, k % 32, (k + 7) % 32, 0,
                                          (k > 0) ? 7 + k : 0, 0, 0));
        end
        end_test("freeing and reuse");
        for (int k = 0; k < DEPTH; k++) begin
            table_rows.push_back(make_row(1, k + 1, k, (k + 16) % 32, 0, 0, 0, 0));
        end
        table_rows.push_back(make_row(1, 9, 1, 2, 0, 0, 0, 1));   // dropped
        table_rows.push_back(make_row(0, 0, 0, 0, 48, 0, 0, 1));
        table_rows.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 1));   // head commits
        table_rows.push_back(make_row(1, 10, 3, 4, 0, 0, 0, 0));  // seq 64
        end_test("rob full");
        for (int k = 0; k < 4; k++) begin
            table_rows.push_back(make_row(1, 11 + k, 11, 12, 0, 0, 0, 0));  // seq 65 to 68
        end
        table_rows.push_back(make_row(0, 0, 0, 0, 67, 65, 68, 0));
        table_rows.push_back(make_row(0, 0, 0, 0, 66, 0, 0, 0));
        end_test("simultaneous completions");
    endtask

    initial begin
        int row_idx;
        int err_before;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_rd    = '0;
        dispatch_rs1   = '0;
        dispatch_rs2   = '0;
        add_cdb        = '0;
        mul_cdb        = '0;
        div_cdb        = '0;
        rng            = 32'he665_a61b;
        errors         = 0;
        commits        = 0;
        next_seq       = 1;
        tail_idx       = '0;
        for (int i = 0; i < ARCH; i++) begin
            m_rat[i] = phys_reg_t'(i);
            m_rrf[i] = phys_reg_t'(i);
            fl_q.push_back(phys_reg_t'(ARCH + i));
        end
        build_table();
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        row_idx = 0;
        for (int t = 0; t < test_names.size(); t++) begin
            err_before = errors;
            while (row_idx < test_last[t]) begin
                run_row(table_rows[row_idx]);
                row_idx++;
            end
            drain_rob();
            $display("test %0d %s: %0d errors", t + 1, test_names[t], errors - err_before);
        end

        err_before = errors;
        for (int k = 0; k < RANDOM_ROWS; k++) begin
            random_row(1'b1);
        end
        drain_rob();
        $display("test 6 random run: %0d errors", errors - err_before);

        errors += dut0.u_rob.u_rob_sva.fail_count;
        $display("tests 6, commits %0d, assertion failures %0d, errors %0d",
                 commits, dut0.u_rob.u_rob_sva.fail_count, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/rob.sv
rtl/free_list.sv
rtl/rat.sv
rtl/rrf.sv
rtl/rename_commit.sv
dv/rename_commit_sva.sv
dv/rename_commit_tb.sv

//--- Bender.yml
package:
  name: rename_commit

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rename_pkg.sv
      - rtl/rob.sv
      - rtl/free_list.sv
      - rtl/rat.sv
      - rtl/rrf.sv
      - rtl/rename_commit.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/rename_commit_sva.sv
      - dv/rename_commit_tb.sv
